/* sim.f */
hw/vmem_pkg.sv
hw/vmem_ifs.sv
hw/address_scheduler.sv
hw/vector_memory_stage.sv
hw/dcache_model.sv
hw/vector_memory_top.sv
tests/vector_memory_asserts.sv
tests/vector_memory_tb.sv

/* Makefile */
# Verilator build and run for the vector memory stage testbench
# Override any variable on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP ?= vector_memory_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/vector_memory_tb.sv */
//==============================
// Vector memory stage testbench
// Random store and load, misalignment,
// writeback latch and vsetvl checks
//==============================
`timescale 1ns/1ps

module vector_memory_tb import vmem_pkg::*; ();

  localparam int N_ITER = 16;
  localparam int N_CFG = 6;
  // Five memory steps per iteration, configs, one stall and flush step
  localparam int N_STEPS = N_ITER * 5 + N_CFG + 1;

  logic CLK;
  logic nRST;
  logic in_valid;
  logic [WORD_W-1:0] alu0, alu1, sdat0, sdat1;
  eew_t eew_in;
  logic load_ena, store_ena;
  logic [1:0] lane_wen;
  logic [WORD_W-1:0] woffset0, woffset1;
  logic rd_wen;
  logic [4:0] rd_sel;
  logic [WORD_W-1:0] rd_data;
  cfg_t cfg_type;
  logic [WORD_W-1:0] next_vtype, next_avl;
  logic stall_mem, flush_mem;
  logic busy_mem, exception_mem, csr_update, wb_valid;
  logic [1:0] wb_wen;
  logic [WORD_W-1:0] wb_wdat0, wb_wdat1, wb_woffset0, wb_woffset1;
  logic wb_rd_wen;
  logic [4:0] wb_rd_sel;
  logic [WORD_W-1:0] wb_rd_data, wb_vl;
  sew_t wb_sew;
  vlmul_t wb_lmul;

  // Expected cache contents
  logic [WORD_W-1:0] shadow [MEM_WORDS];
  logic [31:0] rng;

  vector_memory_top DUT (.*);

  always #50 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng = x;
    return x;
  endfunction

  // Word index in bits 9:2, offset on the element boundary
  function automatic logic [31:0] rand_addr(input eew_t w);
    logic [31:0] r;
    r = next_rand();
    case (w)
      EEW8: return {22'd0, r[9:0]};
      EEW16: return {22'd0, r[9:1], 1'b0};
      default: return {22'd0, r[9:2], 2'b00};
    endcase
  endfunction

  // Element of 1, 2 or 4 bytes
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input eew_t w);
    logic [31:0] word;
    int nbytes;
    word = shadow[addr[9:2]] >> (8 * addr[1:0]);
    nbytes = 1 << w;
    return (nbytes == 4) ? word : word & ((32'd1 << (8 * nbytes)) - 1);
  endfunction

  task automatic shadow_store(input logic [31:0] addr, input logic [31:0] data, input eew_t w);
    int nbytes;
    nbytes = 1 << w;
    for (int b = 0; b < nbytes; b++) begin
      shadow[addr[9:2]][8 * (addr[1:0] + b) +: 8] = data[8 * b +: 8];
    end
  endtask

  // Hold the step until the scheduler finishes or refuses it, then retire it
  task automatic present_mem(input logic st, input eew_t w, input logic [1:0] lanes,
                             input logic [31:0] a0, input logic [31:0] a1,
                             input logic [31:0] d0, input logic [31:0] d1,
                             output logic saw_exc, output int busy_cycles);
    int waited;
    busy_cycles = 0;
    saw_exc = 1'b0;
    waited = 0;
    @(posedge CLK);
    in_valid <= 1'b1;
    load_ena <= !st;
    store_ena <= st;
    eew_in <= w;
    lane_wen <= lanes;
    alu0 <= a0;
    alu1 <= a1;
    sdat0 <= d0;
    sdat1 <= d1;
    do begin
      @(negedge CLK);
      waited++;
      if (busy_mem) busy_cycles++;
      if (exception_mem) saw_exc = 1'b1;
      if (waited > 40) abort_run("Timeout: a memory step never released busy");
    end while (busy_mem || (busy_cycles == 0 && !saw_exc));
    @(posedge CLK);
    in_valid <= 1'b0;
    load_ena <= 1'b0;
    store_ena <= 1'b0;
    @(negedge CLK);
  endtask

  // Non-memory or vsetvl step, latched one cycle later
  task automatic present_plain(input cfg_t cfg, input logic [31:0] x0, input logic [31:0] x1,
                               input logic [31:0] rdd, input logic [31:0] vt,
                               input logic [31:0] avl, input logic hold);
    @(posedge CLK);
    in_valid <= 1'b1;
    cfg_type <= cfg;
    alu0 <= x0;
    alu1 <= x1;
    woffset0 <= ~x0;
    woffset1 <= ~x1;
    lane_wen <= 2'b11;
    rd_wen <= 1'b1;
    rd_sel <= x0[4:0];
    rd_data <= rdd;
    next_vtype <= vt;
    next_avl <= avl;
    @(negedge CLK);
    assert (csr_update == (cfg != NOT_CFG))
      else abort_run($sformatf("FAIL %0t: csr_update %b for cfg %0d", $time, csr_update, cfg));
    @(posedge CLK);
    in_valid <= 1'b0;
    cfg_type <= NOT_CFG;
    rd_wen <= 1'b0;
    stall_mem <= hold;
    @(negedge CLK);
  endtask

  task automatic check_plain(input logic [31:0] x0, input logic [31:0] x1,
                             input logic [31:0] rdd);
    assert (wb_valid && wb_wen == 2'b11 && wb_wdat0 == x0 && wb_wdat1 == x1)
      else abort_run($sformatf("FAIL %0t: pass-through got %h %h expected %h %h",
                               $time, wb_wdat0, wb_wdat1, x0, x1));
    assert (wb_woffset0 == ~x0 && wb_woffset1 == ~x1 && wb_rd_wen
            && wb_rd_sel == x0[4:0] && wb_rd_data == rdd)
      else abort_run($sformatf("FAIL %0t: rd or offset not passed through", $time));
  endtask

  task automatic check_timing(input logic [1:0] lanes, input logic exc, input int nbusy);
    assert (!exc && nbusy == $countones(lanes) * (MEM_LATENCY + 1))
      else abort_run($sformatf("FAIL %0t: busy lasted %0d cycles for lanes %b, exception %b",
                               $time, nbusy, lanes, exc));
  endtask

  task automatic check_load(input logic [1:0] lanes, input eew_t w,
                            input logic [31:0] a0, input logic [31:0] a1);
    logic [31:0] e0;
    logic [31:0] e1;
    e0 = expect_load(a0, w);
    e1 = expect_load(a1, w);
    assert (wb_valid && wb_wen == lanes)
      else abort_run($sformatf("FAIL %0t: load wb_wen %b expected %b", $time, wb_wen, lanes));
    assert (!lanes[0] || wb_wdat0 == e0)
      else abort_run($sformatf("FAIL %0t: lane 0 load at %h got %h expected %h",
                               $time, a0, wb_wdat0, e0));
    assert (!lanes[1] || wb_wdat1 == e1)
      else abort_run($sformatf("FAIL %0t: lane 1 load at %h got %h expected %h",
                               $time, a1, wb_wdat1, e1));
  endtask

  // Step reaches writeback the cycle after busy falls
  a_wb_after_busy: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(busy_mem) |=> wb_valid)
    else abort_run($sformatf("FAIL %0t: no wb_valid after busy fell", $time));

  // Exception is a one-cycle pulse with no access
  a_exc_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    exception_mem |-> !busy_mem ##1 !exception_mem)
    else abort_run($sformatf("FAIL %0t: exception pulse malformed", $time));

  a_wb_once: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_valid && !stall_mem) |=> !wb_valid)
    else abort_run($sformatf("FAIL %0t: wb_valid longer than one cycle", $time));

  initial begin
    logic [31:0] a0, a1, d0, d1, r;
    logic [7:0] vlmax;
    logic [7:0] exp_vl;
    eew_t w;
    logic [1:0] lanes;
    logic exc;
    int nbusy;
    rng = 32'd28178;
    CLK = 1'b0;
    nRST = 1'b0;
    in_valid = 1'b0;
    {alu0, alu1, sdat0, sdat1} = '0;
    eew_in = EEW8;
    {load_ena, store_ena, lane_wen, rd_wen, rd_sel} = '0;
    {woffset0, woffset1, rd_data, next_vtype, next_avl} = '0;
    cfg_type = NOT_CFG;
    stall_mem = 1'b0;
    flush_mem = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = '0;
    end
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    assert (!busy_mem && !exception_mem && !wb_valid && wb_wen == 2'b00 && !wb_rd_wen
            && wb_vl == '0 && wb_sew == SEW8 && wb_lmul == LMUL1)
      else abort_run($sformatf("FAIL %0t: outputs not cleared by reset", $time));

    // Pass-through, held by stall, then cleared by flush
    a0 = next_rand();
    a1 = next_rand();
    r = next_rand();
    present_plain(NOT_CFG, a0, a1, r, '0, '0, 1'b1);
    check_plain(a0, a1, r);
    repeat (3) begin
      @(negedge CLK);
      check_plain(a0, a1, r);
    end
    @(posedge CLK);
    flush_mem <= 1'b1;
    @(posedge CLK);
    flush_mem <= 1'b0;
    stall_mem <= 1'b0;
    @(negedge CLK);
    assert (!wb_valid && wb_wen == 2'b00)
      else abort_run($sformatf("FAIL %0t: flush left wb_valid %b wb_wen %b",
                               $time, wb_valid, wb_wen));

    // vsetvl with avl below and above VLENB over element bytes
    for (int k = 0; k < N_CFG; k++) begin
      a0 = next_rand();
      a0[5] = 1'b0;
      r = next_rand();
      a1 = {r[31:8], 3'b000, r[4:0]};
      vlmax = 8'(VLENB / (1 << a0[4:3]));
      exp_vl = (a1[7:0] > vlmax) ? vlmax : a1[7:0];
      present_plain(k[0] ? VSETVL : VSETVLI, r, ~r, r, a0, a1, 1'b0);
      assert (wb_valid && wb_sew == a0[5:3] && wb_lmul == a0[2:0])
        else abort_run($sformatf("FAIL %0t: sew %0d lmul %0d for vtype %h",
                                 $time, wb_sew, wb_lmul, a0));
      assert (wb_vl == 32'(exp_vl) && wb_rd_data == 32'(exp_vl))
        else abort_run($sformatf("FAIL %0t: vl %0d rd %0d expected %0d",
                                 $time, wb_vl, wb_rd_data, exp_vl));
    end

    for (int it = 0; it < N_ITER; it++) begin
      w = eew_t'(next_rand() % 3);
      lanes = 2'(next_rand() % 3 + 1);
      a0 = rand_addr(w);
      a1 = rand_addr(w);
      d0 = next_rand();
      d1 = next_rand();
      present_mem(1'b1, w, lanes, a0, a1, d0, d1, exc, nbusy);
      if (lanes[0]) shadow_store(a0, d0, w);
      if (lanes[1]) shadow_store(a1, d1, w);
      check_timing(lanes, exc, nbusy);
      assert (wb_valid && wb_wen == 2'b00)
        else abort_run($sformatf("FAIL %0t: store wrote registers %b", $time, wb_wen));
      present_mem(1'b0, w, lanes, a0, a1, '0, '0, exc, nbusy);
      check_timing(lanes, exc, nbusy);
      check_load(lanes, w, a0, a1);
      // Whole words around the stored elements
      present_mem(1'b0, EEW32, lanes, {a0[31:2], 2'b00}, {a1[31:2], 2'b00}, '0, '0, exc, nbusy);
      check_timing(lanes, exc, nbusy);
      check_load(lanes, EEW32, {a0[31:2], 2'b00}, {a1[31:2], 2'b00});
      // Odd offset faults for 16 and 32 bit elements
      w = (next_rand() & 1) ? EEW32 : EEW16;
      r = next_rand();
      a0 = rand_addr(w);
      a1 = {22'd0, r[9:2], r[1], 1'b1};
      if (it[0]) {a0, a1} = {a1, a0};
      present_mem(r[12], w, 2'b11, a0, a1, next_rand(), next_rand(), exc, nbusy);
      assert (exc && nbusy == 0 && wb_valid && wb_wen == 2'b00)
        else abort_run($sformatf("FAIL %0t: misaligned step exc %b busy %0d wb_wen %b",
                                 $time, exc, nbusy, wb_wen));
      present_mem(1'b0, EEW32, 2'b11, {a0[31:2], 2'b00}, {a1[31:2], 2'b00}, '0, '0, exc, nbusy);
      check_timing(2'b11, exc, nbusy);
      check_load(2'b11, EEW32, {a0[31:2], 2'b00}, {a1[31:2], 2'b00});
    end

    $display("All tests passed!");
    $finish;
  end

  // Watchdog sized from the step count
  initial begin
    repeat (N_STEPS * 10 + 100) @(posedge CLK);
    abort_run("Timeout: the run did not finish within its cycle budget");
  end

endmodule

/* tests/vector_memory_asserts.sv */
//==============================
// Scheduler to cache protocol assertions
// Bound into address_scheduler
//==============================
`timescale 1ns/1ps

module vector_memory_asserts import vmem_pkg::*; (
  input logic CLK,
  input logic nRST,
  input logic ren,
  input logic wen,
  input logic dhit,
  input logic [3:0] byte_ena
);

  logic strobe;

  assign strobe = ren | wen;

  // One access kind at a time
  a_one_kind: assert property (@(posedge CLK) disable iff (!nRST)
    !(ren && wen))
    else $error("ren and wen are high together");

  // Strobe level stays put until its dhit
  a_strobe_held: assert property (@(posedge CLK) disable iff (!nRST)
    (strobe && !dhit) |=> (ren == $past(ren) && wen == $past(wen)))
    else $error("strobe dropped or changed before dhit");

  // New access is a rising strobe or a strobe kept past a dhit
  a_latency: assert property (@(posedge CLK) disable iff (!nRST)
    (strobe && (!$past(strobe) || $past(dhit))) |=> !dhit ##(MEM_LATENCY-1) dhit)
    else $error("dhit not at the fixed cache latency");

  a_byte_ena: assert property (@(posedge CLK) disable iff (!nRST)
    strobe |-> byte_ena != 4'b0000)
    else $error("strobe with no byte enabled");

endmodule

bind address_scheduler vector_memory_asserts u_asserts (
  .CLK(CLK), .nRST(nRST), .ren(cif.ren), .wen(cif.wen), .dhit(cif.dhit),
  .byte_ena(cif.byte_ena)
);

/* hw/vector_memory_top.sv */
//============================
// Vector memory top level
// Stage, scheduler and cache model
//============================
`timescale 1ns/1ps

module vector_memory_top import vmem_pkg::*; (
  input logic CLK,
  input logic nRST,
  input logic in_valid,
  input logic [WORD_W-1:0] alu0,
  input logic [WORD_W-1:0] alu1,
  input logic [WORD_W-1:0] sdat0,
  input logic [WORD_W-1:0] sdat1,
  input eew_t eew_in,
  input logic load_ena,
  input logic store_ena,
  input logic [1:0] lane_wen,
  input logic [WORD_W-1:0] woffset0,
  input logic [WORD_W-1:0] woffset1,
  input logic rd_wen,
  input logic [4:0] rd_sel,
  input logic [WORD_W-1:0] rd_data,
  input cfg_t cfg_type,
  input logic [WORD_W-1:0] next_vtype,
  input logic [WORD_W-1:0] next_avl,
  input logic stall_mem,
  input logic flush_mem,
  output logic busy_mem,
  output logic exception_mem,
  output logic csr_update,
  output logic wb_valid,
  output logic [1:0] wb_wen,
  output logic [WORD_W-1:0] wb_wdat0,
  output logic [WORD_W-1:0] wb_wdat1,
  output logic [WORD_W-1:0] wb_woffset0,
  output logic [WORD_W-1:0] wb_woffset1,
  output logic wb_rd_wen,
  output logic [4:0] wb_rd_sel,
  output logic [WORD_W-1:0] wb_rd_data,
  output logic [WORD_W-1:0] wb_vl,
  output sew_t wb_sew,
  output vlmul_t wb_lmul
);

  addr_sched_if asif ();
  dcache_if cif ();

  // Stage ports share the top level names
  vector_memory_stage u_stage (.*);
  address_scheduler u_sched (.CLK(CLK), .nRST(nRST), .as(asif), .cif(cif));
  dcache_model u_cache (.CLK(CLK), .nRST(nRST), .cif(cif));

  // Hazard status straight from the scheduler
  assign busy_mem = asif.busy;
  assign exception_mem = asif.exception;

endmodule

/* hw/dcache_model.sv */
//============================
// Data cache model
// Word memory, fixed-latency dhit,
// byte-enabled writes
//============================
`timescale 1ns/1ps

module dcache_model import vmem_pkg::*; (
  input logic CLK,
  input logic nRST,
  dcache_if.slave cif
);

  logic [WORD_W-1:0] mem [MEM_WORDS];
  logic [LAT_W-1:0] lat_cnt;
  logic [MEM_AW-1:0] widx;
  logic [WORD_W-1:0] merged;

  assign widx = cif.dmemaddr[MEM_AW+1:2];

  // Old word with enabled store bytes replaced
  always_comb begin
    merged = mem[widx];
    for (int b = 0; b < 4; b++) begin
      if (cif.byte_ena[b]) begin
        merged[8*b +: 8] = cif.dmemstore[8*b +: 8];
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
      cif.dhit <= 1'b0;
      cif.dmemload <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      cif.dhit <= 1'b0;
      // A strobe still high after dhit is a new access
      if (cif.dhit || !(cif.ren || cif.wen)) begin
        lat_cnt <= '0;
      end else if (lat_cnt == LAT_W'(MEM_LATENCY - 1)) begin
        cif.dhit <= 1'b1;
        lat_cnt <= '0;
        if (cif.wen) begin
          mem[widx] <= merged;
        end else begin
          // Read word held until the next read
          cif.dmemload <= mem[widx];
        end
      end else begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

endmodule

/* hw/vector_memory_stage.sv */
//============================
// Vector memory stage
// Load buffer and alignment, writeback latch,
// vl and vtype configuration registers
//============================
`timescale 1ns/1ps

module vector_memory_stage import vmem_pkg::*; (
  input logic CLK,
  input logic nRST,
  input logic in_valid,
  input logic [WORD_W-1:0] alu0,
  input logic [WORD_W-1:0] alu1,
  input logic [WORD_W-1:0] sdat0,
  input logic [WORD_W-1:0] sdat1,
  input eew_t eew_in,
  input logic load_ena,
  input logic store_ena,
  input logic [1:0] lane_wen,
  input logic [WORD_W-1:0] woffset0,
  input logic [WORD_W-1:0] woffset1,
  input logic rd_wen,
  input logic [4:0] rd_sel,
  input logic [WORD_W-1:0] rd_data,
  input cfg_t cfg_type,
  input logic [WORD_W-1:0] next_vtype,
  input logic [WORD_W-1:0] next_avl,
  input logic stall_mem,
  input logic flush_mem,
  output logic csr_update,
  output logic wb_valid,
  output logic [1:0] wb_wen,
  output logic [WORD_W-1:0] wb_wdat0,
  output logic [WORD_W-1:0] wb_wdat1,
  output logic [WORD_W-1:0] wb_woffset0,
  output logic [WORD_W-1:0] wb_woffset1,
  output logic wb_rd_wen,
  output logic [4:0] wb_rd_sel,
  output logic [WORD_W-1:0] wb_rd_data,
  output logic [WORD_W-1:0] wb_vl,
  output sew_t wb_sew,
  output vlmul_t wb_lmul,
  addr_sched_if.stage asif,
  dcache_if.monitor cif
);

  function automatic logic [WORD_W-1:0] elem_mask(input eew_t w);
    case (w)
      EEW8: elem_mask = 32'h0000_00ff;
      EEW16: elem_mask = 32'h0000_ffff;
      default: elem_mask = '1;
    endcase
  endfunction

  logic mem_step;
  logic started;
  logic start;
  logic latch_en;
  logic is_cfg;
  logic [1:0] got;
  logic [1:0] wen_eff;
  logic [WORD_W-1:0] data0;
  logic [WORD_W-1:0] load0;
  logic [WORD_W-1:0] load1;
  logic [WORD_W-1:0] wdat0;
  logic [WORD_W-1:0] wdat1;
  logic [7:0] avl8;
  logic [7:0] vlmax;
  logic [7:0] next_vl;
  logic [WORD_W-1:0] vl;
  vtype_u vtype;
  vtype_u new_vtype;

  assign mem_step = load_ena | store_ena;
  // One start per memory step, held off once issued
  assign start = in_valid & mem_step & ~asif.busy & ~started;
  // Step leaves once the scheduler is done with it
  assign latch_en = in_valid & ~asif.busy & ~start & ~stall_mem;

  assign asif.addr0 = alu0;
  assign asif.addr1 = alu1;
  assign asif.storedata0 = sdat0;
  assign asif.storedata1 = sdat1;
  assign asif.eew = eew_in;
  assign asif.load_ena = load_ena;
  assign asif.store_ena = store_ena;
  // Register write lanes double as the active lanes
  assign asif.lane_ena = lane_wen;
  assign asif.start = start;

  // Start issued, and which lanes have returned data
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      started <= 1'b0;
      got <= 2'b00;
    end else if (latch_en || flush_mem) begin
      started <= 1'b0;
      got <= 2'b00;
    end else begin
      if (start) begin
        started <= 1'b1;
      end
      if (asif.arrived0) begin
        got[0] <= 1'b1;
      end
      if (asif.arrived1) begin
        got[1] <= 1'b1;
      end
    end
  end

  // Lane 0 word kept while lane 1 is fetched
  always_ff @(posedge CLK) begin
    if (asif.arrived0) begin
      data0 <= cif.dmemload;
    end
  end

  // Lane 1 word still sits on dmemload from its dhit
  assign load0 = (data0 >> {alu0[1:0], 3'b000}) & elem_mask(eew_in);
  assign load1 = (cif.dmemload >> {alu1[1:0], 3'b000}) & elem_mask(eew_in);
  assign wdat0 = load_ena ? load0 : alu0;
  assign wdat1 = load_ena ? load1 : alu1;

  // Stores write no register, loads only lanes that arrived
  always_comb begin
    if (store_ena) begin
      wen_eff = 2'b00;
    end else if (load_ena) begin
      wen_eff = lane_wen & got;
    end else begin
      wen_eff = lane_wen;
    end
  end

  // Writeback latch control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid <= 1'b0;
      wb_wen <= 2'b00;
      wb_rd_wen <= 1'b0;
    end else if (flush_mem) begin
      wb_valid <= 1'b0;
      wb_wen <= 2'b00;
      wb_rd_wen <= 1'b0;
    end else if (!stall_mem) begin
      wb_valid <= latch_en;
      wb_wen <= latch_en ? wen_eff : 2'b00;
      wb_rd_wen <= latch_en & rd_wen & ~asif.exception;
    end
  end

  // Writeback payload
  always_ff @(posedge CLK) begin
    if (latch_en) begin
      wb_wdat0 <= wdat0;
      wb_wdat1 <= wdat1;
      wb_woffset0 <= woffset0;
      wb_woffset1 <= woffset1;
      wb_rd_sel <= rd_sel;
      // Config instructions return the new vl in rd
      wb_rd_data <= is_cfg ? {{(WORD_W-8){1'b0}}, next_vl} : rd_data;
    end
  end

  // vl capped at VLENB over element bytes of the new sew
  assign is_cfg = (cfg_type != NOT_CFG);
  assign csr_update = in_valid & is_cfg;
  assign new_vtype.raw = next_vtype;
  assign avl8 = next_avl[7:0];
  assign vlmax = 8'(VLENB >> new_vtype.f.vsew);
  assign next_vl = (avl8 > vlmax) ? vlmax : avl8;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl <= '0;
      vtype.raw <= '0;
    end else if (latch_en && is_cfg && !flush_mem) begin
      vl <= {{(WORD_W-8){1'b0}}, next_vl};
      vtype.raw <= new_vtype.raw;
    end
  end

  assign wb_vl = vl;
  assign wb_sew = vtype.f.vsew;
  assign wb_lmul = vtype.f.vlmul;

endmodule

/* hw/address_scheduler.sv */
//============================
// Address scheduler
// Per-lane access FSM, byte enables,
// store alignment, misalignment check
//============================
`timescale 1ns/1ps

module address_scheduler import vmem_pkg::*; (
  input logic CLK,
  input logic nRST,
  addr_sched_if.sched as,
  dcache_if.master cif
);

  // Element must sit on its natural boundary
  function automatic logic misaligned(input logic [1:0] off, input eew_t w);
    case (w)
      EEW16: misaligned = off[0];
      EEW32: misaligned = |off;
      default: misaligned = 1'b0;
    endcase
  endfunction

  // Bytes of the word touched by one element
  function automatic logic [3:0] lane_bytes(input logic [1:0] off, input eew_t w);
    case (w)
      EEW8: lane_bytes = 4'b0001 << off;
      EEW16: lane_bytes = 4'b0011 << {off[1], 1'b0};
      default: lane_bytes = 4'b1111;
    endcase
  endfunction

  logic [1:0] state;
  logic exc_q;
  logic index_q;
  logic busy;
  logic mis0;
  logic mis1;
  logic lane_sel;

  // Step captured at start
  logic [WORD_W-1:0] addr0_q;
  logic [WORD_W-1:0] addr1_q;
  logic [WORD_W-1:0] sdat0_q;
  logic [WORD_W-1:0] sdat1_q;
  eew_t eew_q;
  logic ld_q;
  logic st_q;
  logic lane1_q;

  // Lane being served
  logic [WORD_W-1:0] cur_addr;
  logic [WORD_W-1:0] cur_data;

  // Checked on the live step, only active lanes count
  assign mis0 = as.lane_ena[0] & misaligned(as.addr0[1:0], as.eew);
  assign mis1 = as.lane_ena[1] & misaligned(as.addr1[1:0], as.eew);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      exc_q <= 1'b0;
      index_q <= 1'b0;
    end else begin
      // Exception is a single-cycle pulse
      exc_q <= 1'b0;
      case (state)
        IDLE: begin
          if (as.start) begin
            if (mis0 || mis1) begin
              // Abort the whole step, report first faulting lane
              exc_q <= 1'b1;
              index_q <= ~mis0;
            end else if (as.lane_ena[0]) begin
              state <= LANE0;
            end else if (as.lane_ena[1]) begin
              state <= LANE1;
            end
          end
        end
        LANE0: begin
          if (cif.dhit) begin
            state <= lane1_q ? LANE1 : IDLE;
          end
        end
        LANE1: begin
          if (cif.dhit) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Step payload, only meaningful while busy
  always_ff @(posedge CLK) begin
    if (state == IDLE && as.start) begin
      addr0_q <= as.addr0;
      addr1_q <= as.addr1;
      sdat0_q <= as.storedata0;
      sdat1_q <= as.storedata1;
      eew_q <= as.eew;
      ld_q <= as.load_ena;
      st_q <= as.store_ena;
      lane1_q <= as.lane_ena[1];
    end
  end

  assign busy = (state != IDLE);
  assign lane_sel = (state == LANE1);
  assign cur_addr = lane_sel ? addr1_q : addr0_q;
  assign cur_data = lane_sel ? sdat1_q : sdat0_q;

  // Strobe stays high across back-to-back lanes
  assign cif.ren = busy & ld_q;
  assign cif.wen = busy & st_q;
  assign cif.dmemaddr = {cur_addr[WORD_W-1:2], 2'b00};
  assign cif.byte_ena = lane_bytes(cur_addr[1:0], eew_q);
  // Store element moved up to its byte lane
  assign cif.dmemstore = cur_data << {cur_addr[1:0], 3'b000};

  assign as.busy = busy;
  assign as.exception = exc_q;
  assign as.index = index_q;
  assign as.arrived0 = cif.dhit & (state == LANE0);
  assign as.arrived1 = cif.dhit & lane_sel;

endmodule

/* hw/vmem_ifs.sv */
//============================
// Stage to scheduler interface
// Scheduler to data cache interface
//============================
`timescale 1ns/1ps

interface addr_sched_if import vmem_pkg::*; ();
  // Step handed over by the stage
  logic [WORD_W-1:0] addr0;
  logic [WORD_W-1:0] addr1;
  logic [WORD_W-1:0] storedata0;
  logic [WORD_W-1:0] storedata1;
  eew_t eew;
  logic load_ena;
  logic store_ena;
  logic [1:0] lane_ena;
  // One cycle per memory step
  logic start;

  // Scheduler status
  logic busy;
  logic exception;
  logic arrived0;
  logic arrived1;
  // Lane at fault
  logic index;

  modport stage (
    output addr0, addr1, storedata0, storedata1, eew, load_ena, store_ena, lane_ena, start,
    input busy, exception, arrived0, arrived1, index
  );

  modport sched (
    input addr0, addr1, storedata0, storedata1, eew, load_ena, store_ena, lane_ena, start,
    output busy, exception, arrived0, arrived1, index
  );
endinterface

interface dcache_if import vmem_pkg::*; ();
  // Word aligned access, strobe held until dhit
  logic [WORD_W-1:0] dmemaddr;
  logic [WORD_W-1:0] dmemstore;
  logic ren;
  logic wen;
  logic [3:0] byte_ena;
  // Response
  logic dhit;
  logic [WORD_W-1:0] dmemload;

  modport master (output dmemaddr, dmemstore, ren, wen, byte_ena, input dhit);
  modport slave (input dmemaddr, dmemstore, ren, wen, byte_ena, output dhit, dmemload);
  // Load data tap for the stage
  modport monitor (input dmemload);
endinterface

/* hw/vmem_pkg.sv */
//============================
// Shared vector memory definitions
// Widths, cache latency, scheduler states,
// element width and lmul encodings, vtype union
//============================
package vmem_pkg;

  // Data and address width
  localparam int WORD_W = 32;
  // Cache model depth, word index from address bits 9:2
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW = $clog2(MEM_WORDS);
  // Cycles from strobe to dhit
  localparam int MEM_LATENCY = 2;
  localparam int LAT_W = $clog2(MEM_LATENCY + 1);
  // Vector register length in bytes
  localparam int VLENB = 16;

  // Address scheduler FSM states
  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] LANE0 = 2'd1;
  localparam logic [1:0] LANE1 = 2'd2;

  // Load/store element width
  typedef enum logic [1:0] {EEW8 = 2'd0, EEW16 = 2'd1, EEW32 = 2'd2} eew_t;

  // vtype.vsew
  typedef enum logic [2:0] {SEW8 = 3'd0, SEW16 = 3'd1, SEW32 = 3'd2, SEW64 = 3'd3} sew_t;

  // vtype.vlmul, fractional groups at the top
  typedef enum logic [2:0] {
    LMUL1 = 3'd0, LMUL2 = 3'd1, LMUL4 = 3'd2, LMUL8 = 3'd3,
    LMULF8 = 3'd5, LMULF4 = 3'd6, LMULF2 = 3'd7
  } vlmul_t;

  // Kind of configuration instruction
  typedef enum logic [1:0] {NOT_CFG = 2'd0, VSETVLI = 2'd1, VSETVL = 2'd2} cfg_t;

  // Raw word from execute, or the decoded fields
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      logic [WORD_W-9:0] reserved;
      logic vma;
      logic vta;
      sew_t vsew;
      vlmul_t vlmul;
    } f;
  } vtype_u;

endpackage
